// File: mcpu_core_pkg.sv
package mcpu_core_pkg;

   // ****************************************
   // addresses
   // ****************************************

   typedef logic [31:0] addr_t; // byte address.

   // one bundle holds four 32-bit slots.
   localparam addr_t bundle_bytes = 32'd16;

   // ****************************************
   // pc stage control
   // ****************************************

   // five next-pc sources need three bits.
   typedef enum logic [2:0] {
      pc_sel_hold   = 3'd0, // keep current pc.
      pc_sel_seq    = 3'd1, // advance one bundle.
      pc_sel_branch = 3'd2, // taken branch target.
      pc_sel_vector = 3'd3, // exception handler entry.
      pc_sel_epc    = 3'd4  // return from exception.
   } pc_sel_t;

   typedef enum logic {
      st_run   = 1'b0, // bundles flow normally.
      st_flush = 1'b1  // one dead cycle after a redirect.
   } exn_state_t;

endpackage

// File: mcpu_exn_pkg.sv
package mcpu_exn_pkg;

   // ****************************************
   // cause codes
   // ****************************************

   typedef logic [4:0] exn_code_t;

   localparam exn_code_t exn_code_noerr     = 5'd0; // no fault in this slot.
   localparam exn_code_t exn_code_interrupt = 5'd1; // external interrupt, slot 0 only.
   localparam exn_code_t exn_code_inst_pf   = 5'd2; // instruction fetch page fault.
   localparam exn_code_t exn_code_ill       = 5'd3; // illegal instruction.
   localparam exn_code_t exn_code_dup_dest  = 5'd4; // two slots write one register.
   localparam exn_code_t exn_code_data_pf   = 5'd5; // load/store page fault.
   localparam exn_code_t exn_code_divzero   = 5'd6; // divide by zero.
   localparam exn_code_t exn_code_syscall   = 5'd7; // system call trap.
   localparam exn_code_t exn_code_break     = 5'd8; // breakpoint trap.

   // ****************************************
   // bundle shape
   // ****************************************

   // instructions per bundle, one cause code each.
   localparam int num_slots = 4;

endpackage

// File: exn_encode.sv
module exn_encode (
   input  logic                      d2pc_in_inst_pf,
   input  logic                      d2pc_in_invalid0,
   input  logic                      d2pc_in_invalid1,
   input  logic                      d2pc_in_invalid2,
   input  logic                      d2pc_in_invalid3,
   input  logic                      pc_dup_dest,
   input  logic                      pc_data_pf0,
   input  logic                      pc_data_pf1,
   input  logic                      pc_div_zero,
   input  logic                      pc_syscall,
   input  logic                      pc_break,
   input  logic                      int_pending,
   input  logic                      interrupts_enabled,
   input  logic                      pc_valid,
   output mcpu_exn_pkg::exn_code_t   combined_ec0,
   output mcpu_exn_pkg::exn_code_t   combined_ec1,
   output mcpu_exn_pkg::exn_code_t   combined_ec2,
   output mcpu_exn_pkg::exn_code_t   combined_ec3,
   output logic                      exception
);

   logic any_fault;

   // slot 0 sees every bundle-wide fault as well as its own.
   always_comb begin
      if (int_pending && interrupts_enabled)
         combined_ec0 = mcpu_exn_pkg::exn_code_interrupt;
      else if (d2pc_in_inst_pf)
         combined_ec0 = mcpu_exn_pkg::exn_code_inst_pf;
      else if (d2pc_in_invalid0)
         combined_ec0 = mcpu_exn_pkg::exn_code_ill;
      else if (pc_dup_dest)
         combined_ec0 = mcpu_exn_pkg::exn_code_dup_dest;
      else if (pc_data_pf0)
         combined_ec0 = mcpu_exn_pkg::exn_code_data_pf;
      else if (pc_div_zero)
         combined_ec0 = mcpu_exn_pkg::exn_code_divzero;
      else if (pc_syscall)
         combined_ec0 = mcpu_exn_pkg::exn_code_syscall;
      else if (pc_break)
         combined_ec0 = mcpu_exn_pkg::exn_code_break;
      else
         combined_ec0 = mcpu_exn_pkg::exn_code_noerr;
   end

   // slot 1 has the second memory port.
   always_comb begin
      if (d2pc_in_invalid1)
         combined_ec1 = mcpu_exn_pkg::exn_code_ill;
      else if (pc_data_pf1)
         combined_ec1 = mcpu_exn_pkg::exn_code_data_pf;
      else
         combined_ec1 = mcpu_exn_pkg::exn_code_noerr;
   end

   // alu-only slots can only fail decode.
   assign combined_ec2 = d2pc_in_invalid2 ? mcpu_exn_pkg::exn_code_ill
                                          : mcpu_exn_pkg::exn_code_noerr;
   assign combined_ec3 = d2pc_in_invalid3 ? mcpu_exn_pkg::exn_code_ill
                                          : mcpu_exn_pkg::exn_code_noerr;

   assign any_fault = (combined_ec0 != mcpu_exn_pkg::exn_code_noerr) ||
                      (combined_ec1 != mcpu_exn_pkg::exn_code_noerr) ||
                      (combined_ec2 != mcpu_exn_pkg::exn_code_noerr) ||
                      (combined_ec3 != mcpu_exn_pkg::exn_code_noerr);

   // codes are shown even for an empty stage, only the trap is qualified.
   assign exception = any_fault && pc_valid;

endmodule

// File: exn_control.sv
module exn_control (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   exception,
   input  logic                   pc_valid,
   input  logic                   eret,
   input  logic                   branch_taken,
   output mcpu_core_pkg::pc_sel_t pc_sel,
   output logic                   capture,
   output logic                   restore,
   output logic                   flush
);

   mcpu_core_pkg::exn_state_t state;
   mcpu_core_pkg::exn_state_t state_nx;
   logic                      live; // bundle counts this cycle.

   assign live = pc_valid && (state == mcpu_core_pkg::st_run);

   // ****************************************
   // decision
   // ****************************************

   // exception beats eret, eret beats branch.
   always_comb begin
      pc_sel   = mcpu_core_pkg::pc_sel_hold;
      capture  = 1'b0;
      restore  = 1'b0;
      state_nx = state;
      case (state)
         mcpu_core_pkg::st_run: begin
            if (live) begin
               if (exception) begin
                  pc_sel   = mcpu_core_pkg::pc_sel_vector;
                  capture  = 1'b1;
                  state_nx = mcpu_core_pkg::st_flush;
               end else if (eret) begin
                  pc_sel   = mcpu_core_pkg::pc_sel_epc;
                  restore  = 1'b1;
                  state_nx = mcpu_core_pkg::st_flush;
               end else if (branch_taken) begin
                  pc_sel = mcpu_core_pkg::pc_sel_branch;
               end else begin
                  pc_sel = mcpu_core_pkg::pc_sel_seq;
               end
            end
         end
         mcpu_core_pkg::st_flush: begin
            state_nx = mcpu_core_pkg::st_run; // one cycle, inputs ignored.
         end
         default: begin
            state_nx = mcpu_core_pkg::st_run;
         end
      endcase
   end

   // ****************************************
   // state register
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mcpu_core_pkg::st_run;
      end else begin
         state <= state_nx;
      end
   end

   assign flush = (state == mcpu_core_pkg::st_flush);

endmodule

// File: exn_state_regs.sv
module exn_state_regs (
   input  logic                      rst,
   input  logic                      clk,
   input  logic                      capture,
   input  logic                      restore,
   input  logic                      ie_set,
   input  logic                      ie_clear,
   input  mcpu_core_pkg::addr_t      pc,
   input  mcpu_exn_pkg::exn_code_t   combined_ec0,
   input  mcpu_exn_pkg::exn_code_t   combined_ec1,
   input  mcpu_exn_pkg::exn_code_t   combined_ec2,
   input  mcpu_exn_pkg::exn_code_t   combined_ec3,
   output mcpu_core_pkg::addr_t      epc,
   output mcpu_exn_pkg::exn_code_t   saved_ec0,
   output mcpu_exn_pkg::exn_code_t   saved_ec1,
   output mcpu_exn_pkg::exn_code_t   saved_ec2,
   output mcpu_exn_pkg::exn_code_t   saved_ec3,
   output logic                      interrupts_enabled
);

   mcpu_core_pkg::addr_t    epc_q;
   mcpu_exn_pkg::exn_code_t combined [mcpu_exn_pkg::num_slots];
   mcpu_exn_pkg::exn_code_t saved_q [mcpu_exn_pkg::num_slots];
   logic                    ie_q;
   logic                    saved_ie_q; // one level of nesting only.

   assign combined[0] = combined_ec0;
   assign combined[1] = combined_ec1;
   assign combined[2] = combined_ec2;
   assign combined[3] = combined_ec3;

   // ****************************************
   // exception pc and causes
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         epc_q <= '0;
         for (int i = 0; i < mcpu_exn_pkg::num_slots; i++) begin
            saved_q[i] <= mcpu_exn_pkg::exn_code_noerr;
         end
      end else if (capture) begin
         epc_q <= pc; // address of the faulting bundle.
         for (int i = 0; i < mcpu_exn_pkg::num_slots; i++) begin
            saved_q[i] <= combined[i];
         end
      end
   end

   // ****************************************
   // interrupt enable
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         ie_q       <= 1'b0;
         saved_ie_q <= 1'b0;
      end else if (capture) begin
         saved_ie_q <= ie_q;
         ie_q       <= 1'b0; // handler starts masked.
      end else if (restore) begin
         ie_q <= saved_ie_q;
      end else if (ie_clear) begin
         ie_q <= 1'b0; // clear beats set.
      end else if (ie_set) begin
         ie_q <= 1'b1;
      end
   end

   assign epc                = epc_q;
   assign saved_ec0          = saved_q[0];
   assign saved_ec1          = saved_q[1];
   assign saved_ec2          = saved_q[2];
   assign saved_ec3          = saved_q[3];
   assign interrupts_enabled = ie_q;

endmodule

// File: pc_sequencer.sv
module pc_sequencer #(
   parameter mcpu_core_pkg::addr_t reset_vector = 32'h0000_0000,
   parameter mcpu_core_pkg::addr_t exn_vector   = 32'h0000_0100
) (
   input  logic                   clk,
   input  logic                   rst,
   input  mcpu_core_pkg::pc_sel_t pc_sel,
   input  mcpu_core_pkg::addr_t   branch_target,
   input  mcpu_core_pkg::addr_t   epc,
   output mcpu_core_pkg::addr_t   pc
);

   mcpu_core_pkg::addr_t pc_q;
   mcpu_core_pkg::addr_t pc_nx;
   mcpu_core_pkg::addr_t pc_inc;

   assign pc_inc = pc_q + mcpu_core_pkg::bundle_bytes;

   // ****************************************
   // next address
   // ****************************************

   always_comb begin
      case (pc_sel)
         mcpu_core_pkg::pc_sel_seq: begin
            pc_nx = pc_inc;
         end
         mcpu_core_pkg::pc_sel_branch: begin
            pc_nx = branch_target;
         end
         mcpu_core_pkg::pc_sel_vector: begin
            pc_nx = exn_vector; // single handler entry for all causes.
         end
         mcpu_core_pkg::pc_sel_epc: begin
            pc_nx = epc;
         end
         default: begin
            pc_nx = pc_q; // stalled or flushing.
         end
      endcase
   end

   // ****************************************
   // program counter
   // ****************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q <= reset_vector;
      end else begin
         pc_q <= pc_nx;
      end
   end

   assign pc = pc_q;

endmodule

// File: mcpu_exn_unit.sv
module mcpu_exn_unit #(
   parameter mcpu_core_pkg::addr_t reset_vector = 32'h0000_0000,
   parameter mcpu_core_pkg::addr_t exn_vector   = 32'h0000_0100
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      d2pc_in_inst_pf,
   input  logic                      d2pc_in_invalid0,
   input  logic                      d2pc_in_invalid1,
   input  logic                      d2pc_in_invalid2,
   input  logic                      d2pc_in_invalid3,
   input  logic                      pc_dup_dest,
   input  logic                      pc_data_pf0,
   input  logic                      pc_data_pf1,
   input  logic                      pc_div_zero,
   input  logic                      pc_syscall,
   input  logic                      pc_break,
   input  logic                      int_pending,
   input  logic                      pc_valid,
   input  logic                      eret,
   input  logic                      branch_taken,
   input  mcpu_core_pkg::addr_t      branch_target,
   input  logic                      ie_set,
   input  logic                      ie_clear,
   output mcpu_core_pkg::addr_t      pc,
   output mcpu_core_pkg::addr_t      epc,
   output mcpu_exn_pkg::exn_code_t   saved_ec0,
   output mcpu_exn_pkg::exn_code_t   saved_ec1,
   output mcpu_exn_pkg::exn_code_t   saved_ec2,
   output mcpu_exn_pkg::exn_code_t   saved_ec3,
   output mcpu_exn_pkg::exn_code_t   combined_ec0,
   output mcpu_exn_pkg::exn_code_t   combined_ec1,
   output mcpu_exn_pkg::exn_code_t   combined_ec2,
   output mcpu_exn_pkg::exn_code_t   combined_ec3,
   output logic                      interrupts_enabled,
   output logic                      flush
);

   logic                   exception;
   logic                   capture;
   logic                   restore;
   mcpu_core_pkg::pc_sel_t pc_sel;

   exn_encode u_encode (
      .d2pc_in_inst_pf    (d2pc_in_inst_pf),
      .d2pc_in_invalid0   (d2pc_in_invalid0),
      .d2pc_in_invalid1   (d2pc_in_invalid1),
      .d2pc_in_invalid2   (d2pc_in_invalid2),
      .d2pc_in_invalid3   (d2pc_in_invalid3),
      .pc_dup_dest        (pc_dup_dest),
      .pc_data_pf0        (pc_data_pf0),
      .pc_data_pf1        (pc_data_pf1),
      .pc_div_zero        (pc_div_zero),
      .pc_syscall         (pc_syscall),
      .pc_break           (pc_break),
      .int_pending        (int_pending),
      .interrupts_enabled (interrupts_enabled),
      .pc_valid           (pc_valid),
      .combined_ec0       (combined_ec0),
      .combined_ec1       (combined_ec1),
      .combined_ec2       (combined_ec2),
      .combined_ec3       (combined_ec3),
      .exception          (exception)
   );

   exn_control u_control (
      .clk          (clk),
      .rst          (rst),
      .exception    (exception),
      .pc_valid     (pc_valid),
      .eret         (eret),
      .branch_taken (branch_taken),
      .pc_sel       (pc_sel),
      .capture      (capture),
      .restore      (restore),
      .flush        (flush)
   );

   exn_state_regs u_state_regs (
      .rst                (rst),
      .clk                (clk),
      .capture            (capture),
      .restore            (restore),
      .ie_set             (ie_set),
      .ie_clear           (ie_clear),
      .pc                 (pc),
      .combined_ec0       (combined_ec0),
      .combined_ec1       (combined_ec1),
      .combined_ec2       (combined_ec2),
      .combined_ec3       (combined_ec3),
      .epc                (epc),
      .saved_ec0          (saved_ec0),
      .saved_ec1          (saved_ec1),
      .saved_ec2          (saved_ec2),
      .saved_ec3          (saved_ec3),
      .interrupts_enabled (interrupts_enabled)
   );

   pc_sequencer #(
      .reset_vector (reset_vector),
      .exn_vector   (exn_vector)
   ) u_pc_sequencer (
      .clk           (clk),
      .rst           (rst),
      .pc_sel        (pc_sel),
      .branch_target (branch_target),
      .epc           (epc),
      .pc            (pc)
   );

endmodule

// File: tb_mcpu_exn.sv
module tb_mcpu_exn;

   typedef logic [19:0] code_set_t; // four cause codes, slot 0 in the low bits.

   localparam mcpu_core_pkg::addr_t reset_vector = 32'h0000_1000;
   localparam mcpu_core_pkg::addr_t exn_vector   = 32'h0000_0800;

   logic clk;
   logic rst;
   logic d2pc_in_inst_pf;
   logic d2pc_in_invalid0;
   logic d2pc_in_invalid1;
   logic d2pc_in_invalid2;
   logic d2pc_in_invalid3;
   logic pc_dup_dest;
   logic pc_data_pf0;
   logic pc_data_pf1;
   logic pc_div_zero;
   logic pc_syscall;
   logic pc_break;
   logic int_pending;
   logic pc_valid;
   logic eret;
   logic branch_taken;
   logic ie_set;
   logic ie_clear;
   mcpu_core_pkg::addr_t    branch_target;
   mcpu_core_pkg::addr_t    pc;
   mcpu_core_pkg::addr_t    epc;
   mcpu_exn_pkg::exn_code_t saved_ec0;
   mcpu_exn_pkg::exn_code_t saved_ec1;
   mcpu_exn_pkg::exn_code_t saved_ec2;
   mcpu_exn_pkg::exn_code_t saved_ec3;
   mcpu_exn_pkg::exn_code_t combined_ec0;
   mcpu_exn_pkg::exn_code_t combined_ec1;
   mcpu_exn_pkg::exn_code_t combined_ec2;
   mcpu_exn_pkg::exn_code_t combined_ec3;
   logic interrupts_enabled;
   logic flush;

   // reference model state.
   mcpu_core_pkg::addr_t m_pc;
   mcpu_core_pkg::addr_t m_epc;
   code_set_t            m_saved;
   logic                 m_ie;
   logic                 m_saved_ie;
   logic                 m_flush;
   code_set_t            ref_codes;
   code_set_t            cmp_codes;
   logic                 took;

   integer seed;
   int     errors;
   int     timeouts;

   mcpu_exn_unit #(
      .reset_vector (reset_vector),
      .exn_vector   (exn_vector)
   ) uut (
      .clk (clk), .rst (rst),
      .d2pc_in_inst_pf (d2pc_in_inst_pf),
      .d2pc_in_invalid0 (d2pc_in_invalid0), .d2pc_in_invalid1 (d2pc_in_invalid1),
      .d2pc_in_invalid2 (d2pc_in_invalid2), .d2pc_in_invalid3 (d2pc_in_invalid3),
      .pc_dup_dest (pc_dup_dest), .pc_data_pf0 (pc_data_pf0), .pc_data_pf1 (pc_data_pf1),
      .pc_div_zero (pc_div_zero), .pc_syscall (pc_syscall), .pc_break (pc_break),
      .int_pending (int_pending), .pc_valid (pc_valid), .eret (eret),
      .branch_taken (branch_taken), .branch_target (branch_target),
      .ie_set (ie_set), .ie_clear (ie_clear),
      .pc (pc), .epc (epc),
      .saved_ec0 (saved_ec0), .saved_ec1 (saved_ec1),
      .saved_ec2 (saved_ec2), .saved_ec3 (saved_ec3),
      .combined_ec0 (combined_ec0), .combined_ec1 (combined_ec1),
      .combined_ec2 (combined_ec2), .combined_ec3 (combined_ec3),
      .interrupts_enabled (interrupts_enabled), .flush (flush)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ****************************************
   // reference model
   // ****************************************

   function automatic code_set_t ref_encode(input logic ie);
      mcpu_exn_pkg::exn_code_t c0;
      mcpu_exn_pkg::exn_code_t c1;
      mcpu_exn_pkg::exn_code_t c2;
      mcpu_exn_pkg::exn_code_t c3;
      if (int_pending && ie) c0 = mcpu_exn_pkg::exn_code_interrupt;
      else if (d2pc_in_inst_pf) c0 = mcpu_exn_pkg::exn_code_inst_pf;
      else if (d2pc_in_invalid0) c0 = mcpu_exn_pkg::exn_code_ill;
      else if (pc_dup_dest) c0 = mcpu_exn_pkg::exn_code_dup_dest;
      else if (pc_data_pf0) c0 = mcpu_exn_pkg::exn_code_data_pf;
      else if (pc_div_zero) c0 = mcpu_exn_pkg::exn_code_divzero;
      else if (pc_syscall) c0 = mcpu_exn_pkg::exn_code_syscall;
      else if (pc_break) c0 = mcpu_exn_pkg::exn_code_break;
      else c0 = mcpu_exn_pkg::exn_code_noerr;
      if (d2pc_in_invalid1) c1 = mcpu_exn_pkg::exn_code_ill;
      else if (pc_data_pf1) c1 = mcpu_exn_pkg::exn_code_data_pf;
      else c1 = mcpu_exn_pkg::exn_code_noerr;
      c2 = d2pc_in_invalid2 ? mcpu_exn_pkg::exn_code_ill : mcpu_exn_pkg::exn_code_noerr;
      c3 = d2pc_in_invalid3 ? mcpu_exn_pkg::exn_code_ill : mcpu_exn_pkg::exn_code_noerr;
      return {c3, c2, c1, c0};
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         m_pc       = reset_vector;
         m_epc      = '0;
         m_saved    = '0;
         m_ie       = 1'b0;
         m_saved_ie = 1'b0;
         m_flush    = 1'b0;
      end else begin
         ref_codes = ref_encode(m_ie);
         took      = 1'b0;
         if (m_flush) begin
            m_flush = 1'b0; // dead cycle, inputs ignored.
         end else if (pc_valid) begin
            if (ref_codes != '0) begin
               m_epc      = m_pc;
               m_saved    = ref_codes;
               m_saved_ie = m_ie;
               m_ie       = 1'b0;
               m_pc       = exn_vector;
               m_flush    = 1'b1;
               took       = 1'b1;
            end else if (eret) begin
               m_pc    = m_epc;
               m_ie    = m_saved_ie;
               m_flush = 1'b1;
               took    = 1'b1;
            end else if (branch_taken) begin
               m_pc = branch_target;
            end else begin
               m_pc = m_pc + mcpu_core_pkg::bundle_bytes;
            end
         end
         if (!took && ie_clear) m_ie = 1'b0;
         else if (!took && ie_set) m_ie = 1'b1;
      end
   end

   // ****************************************
   // compare
   // ****************************************

   task automatic check_code(input string name, input mcpu_exn_pkg::exn_code_t got,
                             input mcpu_exn_pkg::exn_code_t exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input mcpu_core_pkg::addr_t got,
                             input mcpu_core_pkg::addr_t exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         cmp_codes = ref_encode(m_ie); // enable seen by the encoder this cycle.
         check_code("combined_ec0", combined_ec0, cmp_codes[4:0]);
         check_code("combined_ec1", combined_ec1, cmp_codes[9:5]);
         check_code("combined_ec2", combined_ec2, cmp_codes[14:10]);
         check_code("combined_ec3", combined_ec3, cmp_codes[19:15]);
         check_code("saved_ec0", saved_ec0, m_saved[4:0]);
         check_code("saved_ec1", saved_ec1, m_saved[9:5]);
         check_code("saved_ec2", saved_ec2, m_saved[14:10]);
         check_code("saved_ec3", saved_ec3, m_saved[19:15]);
         check_addr("pc", pc, m_pc);
         check_addr("epc", epc, m_epc);
         check_bit("interrupts_enabled", interrupts_enabled, m_ie);
         check_bit("flush", flush, m_flush);
      end
   end

   // ****************************************
   // stimulus
   // ****************************************

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_idle();
      {d2pc_in_inst_pf, d2pc_in_invalid0, d2pc_in_invalid1, d2pc_in_invalid2} = '0;
      {d2pc_in_invalid3, pc_dup_dest, pc_data_pf0, pc_data_pf1} = '0;
      {pc_div_zero, pc_syscall, pc_break, int_pending} = '0;
      {pc_valid, eret, branch_taken, ie_set, ie_clear} = '0;
      branch_target = '0;
   endtask

   task automatic drive_random();
      int sel;
      sel = $random(seed) & 7;
      d2pc_in_inst_pf  = ($random(seed) & 31) == 0;
      d2pc_in_invalid0 = ($random(seed) & 31) == 0;
      d2pc_in_invalid1 = ($random(seed) & 31) == 0;
      d2pc_in_invalid2 = ($random(seed) & 31) == 0;
      d2pc_in_invalid3 = ($random(seed) & 31) == 0;
      pc_dup_dest      = ($random(seed) & 31) == 0;
      pc_data_pf0      = ($random(seed) & 31) == 0;
      pc_data_pf1      = ($random(seed) & 31) == 0;
      pc_div_zero      = ($random(seed) & 31) == 0;
      pc_syscall       = ($random(seed) & 31) == 0;
      pc_break         = ($random(seed) & 31) == 0;
      int_pending      = ($random(seed) & 3) == 0;
      pc_valid         = ($random(seed) & 3) != 0;
      eret             = ($random(seed) & 7) == 0;
      branch_taken     = ($random(seed) & 3) == 0;
      branch_target    = $random(seed) & 32'hffff_fff0; // bundle aligned.
      ie_set           = (sel == 0);
      ie_clear         = (sel == 1); // never both at once.
   endtask

   task automatic wait_for_flush(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while (flush !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (flush !== 1'b1) begin
         $display("timeout at %0t: no flush cycle within %0d cycles", $time, limit);
         timeouts++;
      end
   endtask

   initial begin
      seed     = 32'hab657412;
      errors   = 0;
      timeouts = 0;
      rst      = 1'b1;
      drive_idle();
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_addr("pc", pc, reset_vector);
      check_bit("flush", flush, 1'b0);
      check_bit("interrupts_enabled", interrupts_enabled, 1'b0);
      check_code("saved_ec0", saved_ec0, mcpu_exn_pkg::exn_code_noerr);
      check_code("saved_ec1", saved_ec1, mcpu_exn_pkg::exn_code_noerr);
      check_code("saved_ec2", saved_ec2, mcpu_exn_pkg::exn_code_noerr);
      check_code("saved_ec3", saved_ec3, mcpu_exn_pkg::exn_code_noerr);

      // enable, then take an interrupt and return from it.
      next_cycle();
      ie_set = 1'b1;
      next_cycle();
      drive_idle();
      pc_valid = 1'b1;
      next_cycle();
      int_pending = 1'b1;
      next_cycle();
      drive_idle();
      wait_for_flush(4);
      next_cycle();
      pc_valid = 1'b1;
      eret     = 1'b1;
      next_cycle();
      drive_idle();
      wait_for_flush(4);

      // masked interrupt advances, then a branch.
      next_cycle();
      ie_clear = 1'b1;
      next_cycle();
      drive_idle();
      pc_valid    = 1'b1;
      int_pending = 1'b1;
      next_cycle();
      drive_idle();
      pc_valid      = 1'b1;
      branch_taken  = 1'b1;
      branch_target = 32'h0000_4440;

      // ie_set loses to a capture at the same edge.
      next_cycle();
      drive_idle();
      pc_valid   = 1'b1;
      pc_syscall = 1'b1;
      ie_set     = 1'b1;
      next_cycle();
      drive_idle();
      wait_for_flush(4);
      next_cycle();
      pc_valid = 1'b1;
      eret     = 1'b1;
      next_cycle();
      drive_idle();
      wait_for_flush(4);

      repeat (2000) begin
         next_cycle();
         drive_random();
      end
      next_cycle();
      drive_idle();
      repeat (3) @(negedge clk);

      $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: mcpu_exn.f
mcpu_core_pkg.sv
mcpu_exn_pkg.sv
exn_encode.sv
exn_control.sv
exn_state_regs.sv
pc_sequencer.sv
mcpu_exn_unit.sv
tb_mcpu_exn.sv
